// ==== include/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define MIPS_RESET_PC 32'h0000_3000

// Opcodes
`define OP_RTYPE 6'h00
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_ORI   6'h0d
`define OP_LUI   6'h0f
`define OP_LB    6'h20
`define OP_LW    6'h23
`define OP_SB    6'h28
`define OP_SW    6'h2b

// R-type function codes
`define FN_ADDU  6'h21
`define FN_SUBU  6'h23
`define FN_OR    6'h25
`define FN_SLT   6'h2a

`define ALU_ADD  3'd0
`define ALU_SUB  3'd1
`define ALU_OR   3'd2
`define ALU_SLT  3'd3
`define ALU_LUI  3'd4

`endif

// ==== rtl/mipsIsaPkg.sv ====
package mipsIsaPkg;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    // One fetched word, viewed either way
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
    } instrT;

    typedef logic [2:0] aluOpT;

    typedef struct packed {
        logic  regWrite;
        logic  memWrite;
        logic  memRead;
        logic  byteAccess;
        logic  aluSrcImm;
        aluOpT aluOp;
        logic  isBranch;
    } ctrlT;

endpackage

// ==== rtl/mipsPipePkg.sv ====
package mipsPipePkg;

    typedef struct packed {
        logic              valid;
        logic [31:0]       pc;
        mipsIsaPkg::ctrlT  ctrl;
        logic [4:0]        rsIdx;
        logic [4:0]        rtIdx;
        logic [4:0]        dest;
        logic [31:0]       rsVal;
        logic [31:0]       rtVal;
        logic [31:0]       imm;
    } decExT;

    typedef struct packed {
        logic              valid;
        logic [31:0]       pc;
        mipsIsaPkg::ctrlT  ctrl;
        logic [4:0]        dest;
        logic [31:0]       aluResult;
        logic [31:0]       storeVal;
    } exMemT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        regWrite;
        logic [4:0]  dest;
        logic [31:0] value;
    } memWbT;

    // Valid only for a write to a nonzero register
    typedef struct packed {
        logic        valid;
        logic [4:0]  dest;
        logic [31:0] value;
    } bypassT;

    typedef struct packed {
        logic [4:0] rsIdx;
        logic [4:0] rtIdx;
        logic       needRsNow;
        logic       needRtNow;
        logic       needRs;
        logic       needRt;
    } hazardReqT;

    // Register zero, then memory, then writeback, then the stored value
    function automatic logic [31:0] forwardVal(input logic [4:0] idx,
                                               input logic [31:0] stored,
                                               input bypassT memSrc,
                                               input bypassT wbSrc);
        if (idx == 5'd0)
            return 32'd0;
        if (memSrc.valid && memSrc.dest == idx)
            return memSrc.value;
        if (wbSrc.valid && wbSrc.dest == idx)
            return wbSrc.value;
        return stored;
    endfunction

endpackage

// ==== rtl/fetchUnit.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module fetchUnit (
    input  logic              clk,
    input  logic              rstN,
    input  logic              stall,
    input  logic              branchTaken,
    input  logic [31:0]       branchTarget,
    input  logic [31:0]       instData,
    output logic [31:0]       instAddr,
    output logic [31:0]       decPc,
    output mipsIsaPkg::instrT decInstr
);
    logic [31:0] pc;

    assign instAddr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `MIPS_RESET_PC;
        end else if (!stall) begin
            // Delay slot is the word fetched now, target comes next
            pc <= branchTaken ? branchTarget : pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decPc    <= 32'd0;
            decInstr <= '0;
        end else if (!stall) begin
            decPc    <= pc;
            decInstr <= instData;
        end
    end

endmodule

// ==== rtl/decodeUnit.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module decodeUnit (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   stall,
    input  logic [31:0]            pc,
    input  mipsIsaPkg::instrT      instr,
    input  mipsPipePkg::bypassT    memBypass,
    input  mipsPipePkg::bypassT    wbBypass,
    input  logic                   wbRegWrite,
    input  logic [4:0]             wbDest,
    input  logic [31:0]            wbValue,
    output logic                   branchTaken,
    output logic [31:0]            branchTarget,
    output mipsPipePkg::hazardReqT hazardReq,
    output mipsPipePkg::decExT     exOut
);
    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    logic [31:0] regFile [32];
    ctrlT        ctrl;
    logic [4:0]  dest;
    logic        useRs;
    logic        useRt;
    logic [31:0] immExt;
    logic [31:0] rsVal;
    logic [31:0] rtVal;

    always_comb begin
        ctrl  = '0;
        dest  = instr.iType.rt;
        useRs = 1'b0;
        useRt = 1'b0;
        case (instr.iType.op)
            `OP_RTYPE: begin
                dest          = instr.rType.rd;
                useRs         = 1'b1;
                useRt         = 1'b1;
                ctrl.regWrite = 1'b1;
                case (instr.rType.funct)
                    `FN_ADDU: ctrl.aluOp = `ALU_ADD;
                    `FN_SUBU: ctrl.aluOp = `ALU_SUB;
                    `FN_OR:   ctrl.aluOp = `ALU_OR;
                    `FN_SLT:  ctrl.aluOp = `ALU_SLT;
                    default: begin
                        // Unknown function runs as a no-op
                        ctrl.regWrite = 1'b0;
                        useRs         = 1'b0;
                        useRt         = 1'b0;
                    end
                endcase
            end
            `OP_ADDIU, `OP_ORI, `OP_LUI: begin
                useRs          = (instr.iType.op != `OP_LUI);
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = (instr.iType.op == `OP_ADDIU) ? `ALU_ADD :
                                 (instr.iType.op == `OP_ORI)   ? `ALU_OR  : `ALU_LUI;
            end
            `OP_LW, `OP_LB: begin
                useRs           = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.memRead    = 1'b1;
                ctrl.aluSrcImm  = 1'b1;
                ctrl.byteAccess = (instr.iType.op == `OP_LB);
            end
            `OP_SW, `OP_SB: begin
                useRs           = 1'b1;
                useRt           = 1'b1;
                ctrl.memWrite   = 1'b1;
                ctrl.aluSrcImm  = 1'b1;
                ctrl.byteAccess = (instr.iType.op == `OP_SB);
            end
            `OP_BEQ, `OP_BNE: begin
                useRs         = 1'b1;
                useRt         = 1'b1;
                ctrl.isBranch = 1'b1;
            end
            default: ;
        endcase
    end

    // ori zero-extends, the rest sign-extend
    assign immExt = (instr.iType.op == `OP_ORI) ? {16'd0, instr.iType.imm} :
                    {{16{instr.iType.imm[15]}}, instr.iType.imm};

    always_ff @(posedge clk) begin
        if (wbRegWrite && wbDest != 5'd0)
            regFile[wbDest] <= wbValue;
    end

    assign rsVal = forwardVal(instr.rType.rs, regFile[instr.rType.rs], memBypass, wbBypass);
    assign rtVal = forwardVal(instr.rType.rt, regFile[instr.rType.rt], memBypass, wbBypass);

    assign branchTaken  = ctrl.isBranch &&
                          ((instr.iType.op == `OP_BNE) ? (rsVal != rtVal) : (rsVal == rtVal));
    assign branchTarget = pc + 32'd4 + {immExt[29:0], 2'b00};

    assign hazardReq.rsIdx     = instr.rType.rs;
    assign hazardReq.rtIdx     = instr.rType.rt;
    assign hazardReq.needRsNow = ctrl.isBranch;
    assign hazardReq.needRtNow = ctrl.isBranch;
    assign hazardReq.needRs    = useRs;
    assign hazardReq.needRt    = useRt;

    always_ff @(posedge clk) begin
        if (!rstN)
            exOut.valid <= 1'b0;
        else
            exOut.valid <= !stall;
        exOut.pc    <= pc;
        exOut.ctrl  <= ctrl;
        exOut.rsIdx <= instr.rType.rs;
        exOut.rtIdx <= instr.rType.rt;
        exOut.dest  <= dest;
        exOut.rsVal <= rsVal;
        exOut.rtVal <= rtVal;
        exOut.imm   <= immExt;
    end

endmodule

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
    input  mipsPipePkg::hazardReqT req,
    input  logic [4:0]             exDest,
    input  logic                   exRegWrite,
    input  logic                   exMemRead,
    output logic                   stall
);
    logic rsHit;
    logic rtHit;
    logic branchWait;
    logic loadWait;

    // Execute produces a register decode reads
    assign rsHit = exRegWrite && exDest != 5'd0 && req.rsIdx == exDest;
    assign rtHit = exRegWrite && exDest != 5'd0 && req.rtIdx == exDest;

    // Branch compares in decode, so any execute result is too late
    assign branchWait = (rsHit && req.needRsNow) || (rtHit && req.needRtNow);

    // Load data only exists once it reaches memory
    assign loadWait = exMemRead && ((rsHit && req.needRs) || (rtHit && req.needRt));

    assign stall = branchWait || loadWait;

endmodule

// ==== rtl/executeUnit.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module executeUnit (
    input  logic                clk,
    input  logic                rstN,
    input  mipsPipePkg::decExT  in,
    input  mipsPipePkg::bypassT memBypass,
    input  mipsPipePkg::bypassT wbBypass,
    output logic [4:0]          exDest,
    output logic                exRegWrite,
    output logic                exMemRead,
    output mipsPipePkg::exMemT  memOut
);
    import mipsPipePkg::*;

    logic [31:0] opA;
    logic [31:0] rtFwd;
    logic [31:0] opB;
    logic [31:0] aluResult;

    assign opA   = forwardVal(in.rsIdx, in.rsVal, memBypass, wbBypass);
    assign rtFwd = forwardVal(in.rtIdx, in.rtVal, memBypass, wbBypass);
    assign opB   = in.ctrl.aluSrcImm ? in.imm : rtFwd;

    always_comb begin
        case (in.ctrl.aluOp)
            `ALU_SUB: aluResult = opA - opB;
            `ALU_OR:  aluResult = opA | opB;
            `ALU_SLT: aluResult = {31'd0, $signed(opA) < $signed(opB)};
            `ALU_LUI: aluResult = {opB[15:0], 16'd0};
            default:  aluResult = opA + opB;
        endcase
    end

    assign exDest     = in.dest;
    assign exRegWrite = in.valid && in.ctrl.regWrite;
    assign exMemRead  = in.valid && in.ctrl.memRead;

    always_ff @(posedge clk) begin
        if (!rstN)
            memOut.valid <= 1'b0;
        else
            memOut.valid <= in.valid;
        memOut.pc        <= in.pc;
        memOut.ctrl      <= in.ctrl;
        memOut.dest      <= in.dest;
        memOut.aluResult <= aluResult;
        memOut.storeVal  <= rtFwd;
    end

endmodule

// ==== rtl/memAccessUnit.sv ====
`timescale 1ns/1ps

module memAccessUnit (
    input  logic                clk,
    input  logic                rstN,
    input  mipsPipePkg::exMemT  in,
    input  logic [31:0]         dataRdata,
    output logic [31:0]         dataAddr,
    output logic [31:0]         dataWdata,
    output logic [3:0]          dataByteEn,
    output mipsPipePkg::bypassT memBypass,
    output mipsPipePkg::memWbT  wbOut
);
    logic [1:0]  lane;
    logic [7:0]  loadByte;
    logic [31:0] finalVal;

    assign dataAddr = in.aluResult;
    assign lane     = in.aluResult[1:0];

    always_comb begin
        dataWdata  = in.storeVal;
        dataByteEn = 4'b0000;
        if (in.valid && in.ctrl.memWrite) begin
            if (in.ctrl.byteAccess) begin
                dataWdata  = {24'd0, in.storeVal[7:0]} << {lane, 3'b000};
                dataByteEn = 4'b0001 << lane;
            end else begin
                dataByteEn = 4'b1111;
            end
        end
    end

    assign loadByte = dataRdata[{lane, 3'b000} +: 8];

    always_comb begin
        if (!in.ctrl.memRead)
            finalVal = in.aluResult;
        else if (in.ctrl.byteAccess)
            finalVal = {{24{loadByte[7]}}, loadByte};
        else
            finalVal = dataRdata;
    end

    assign memBypass.valid = in.valid && in.ctrl.regWrite && in.dest != 5'd0;
    assign memBypass.dest  = in.dest;
    assign memBypass.value = finalVal;

    always_ff @(posedge clk) begin
        if (!rstN)
            wbOut.valid <= 1'b0;
        else
            wbOut.valid <= in.valid;
        wbOut.pc       <= in.pc;
        wbOut.regWrite <= in.ctrl.regWrite;
        wbOut.dest     <= in.dest;
        wbOut.value    <= finalVal;
    end

endmodule

// ==== rtl/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] instData,
    input  logic [31:0] dataRdata,
    output logic [31:0] instAddr,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWdata,
    output logic [3:0]  dataByteEn,
    output logic        grfWe,
    output logic [4:0]  grfAddr,
    output logic [31:0] grfWdata,
    output logic [31:0] wbPc
);
    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    logic        stall;
    logic        branchTaken;
    logic [31:0] branchTarget;
    logic [31:0] decPc;
    instrT       decInstr;
    hazardReqT   hazardReq;
    decExT       decEx;
    exMemT       exMem;
    memWbT       memWb;
    bypassT      memBypass;
    bypassT      wbBypass;
    logic [4:0]  exDest;
    logic        exRegWrite;
    logic        exMemRead;

    // Writeback stage drives the register file, bypass and trace
    assign grfWe    = memWb.valid && memWb.regWrite;
    assign grfAddr  = memWb.dest;
    assign grfWdata = memWb.value;
    assign wbPc     = memWb.pc;

    assign wbBypass.valid = grfWe && memWb.dest != 5'd0;
    assign wbBypass.dest  = memWb.dest;
    assign wbBypass.value = memWb.value;

    fetchUnit uFetch (
        .clk(clk), .rstN(rstN), .stall(stall),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .instData(instData), .instAddr(instAddr),
        .decPc(decPc), .decInstr(decInstr)
    );

    decodeUnit uDecode (
        .clk(clk), .rstN(rstN), .stall(stall),
        .pc(decPc), .instr(decInstr),
        .memBypass(memBypass), .wbBypass(wbBypass),
        .wbRegWrite(grfWe), .wbDest(grfAddr), .wbValue(grfWdata),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .hazardReq(hazardReq), .exOut(decEx)
    );

    hazardUnit uHazard (
        .req(hazardReq), .exDest(exDest),
        .exRegWrite(exRegWrite), .exMemRead(exMemRead), .stall(stall)
    );

    executeUnit uExecute (
        .clk(clk), .rstN(rstN), .in(decEx),
        .memBypass(memBypass), .wbBypass(wbBypass),
        .exDest(exDest), .exRegWrite(exRegWrite), .exMemRead(exMemRead),
        .memOut(exMem)
    );

    memAccessUnit uMemAccess (
        .clk(clk), .rstN(rstN), .in(exMem), .dataRdata(dataRdata),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataByteEn(dataByteEn),
        .memBypass(memBypass), .wbOut(memWb)
    );

endmodule

// ==== sim/tbMemModel.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module tbMemModel (
    input  logic        clk,
    input  logic [31:0] instAddr,
    output logic [31:0] instData,
    input  logic [31:0] dataAddr,
    input  logic [31:0] dataWdata,
    input  logic [3:0]  dataByteEn,
    output logic [31:0] dataRdata
);
    logic [31:0] rom [256];
    logic [31:0] ram [256];
    logic [31:0] expPc [64];
    logic [4:0]  expReg [64];
    logic [31:0] expVal [64];
    logic [31:0] memAddr [16];
    logic [31:0] memWord [16];
    int          progCount;
    int          wbCount;
    int          memCount;
    logic [31:0] romOffset;

    // ROM window starts at the reset PC, anything outside reads as a no-op
    assign romOffset = instAddr - `MIPS_RESET_PC;
    assign instData  = (romOffset < 32'd1024) ? rom[romOffset[9:2]] : 32'd0;
    assign dataRdata = ram[dataAddr[9:2]];

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (dataByteEn[b])
                ram[dataAddr[9:2]][8*b +: 8] <= dataWdata[8*b +: 8];
        end
    end

    function automatic logic [31:0] peekWord(input logic [31:0] addr);
        return ram[addr[9:2]];
    endfunction

    task automatic loadCases(output logic ok);
        int               fd;
        int               n;
        int               r;
        logic [7:0]       kind;
        logic [31:0]      a;
        logic [31:0]      w;
        logic [8*128-1:0] line;
        progCount = 0;
        wbCount   = 0;
        memCount  = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'd0;
            // Background word tied to the byte address
            ram[i] = 32'hA5A5_0000 | (i << 2);
        end
        fd = $fopen("sim/mipsCoreCases.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            line = '0;
            while ($fgets(line, fd) > 0) begin
                kind = 8'd0;
                n = $sscanf(line, "%s", kind);
                case (kind)
                    "P": begin
                        n = $sscanf(line, "%s %h %h", kind, a, w);
                        ok = ok && (n == 3);
                        rom[(a - `MIPS_RESET_PC) >> 2] = w;
                        progCount++;
                    end
                    "D": begin
                        n = $sscanf(line, "%s %h %h", kind, a, w);
                        ok = ok && (n == 3);
                        ram[a[9:2]] = w;
                    end
                    "W": begin
                        n = $sscanf(line, "%s %h %d %h", kind, a, r, w);
                        ok = ok && (n == 4);
                        expPc[wbCount]  = a;
                        expReg[wbCount] = r[4:0];
                        expVal[wbCount] = w;
                        wbCount++;
                    end
                    "M": begin
                        n = $sscanf(line, "%s %h %h", kind, a, w);
                        ok = ok && (n == 3);
                        memAddr[memCount] = a;
                        memWord[memCount] = w;
                        memCount++;
                    end
                    default: ;
                endcase
                line = '0;
            end
            $fclose(fd);
        end
    endtask

endmodule

// ==== sim/tbMipsCore.sv ====
`timescale 1ns/1ps

module tbMipsCore;
    logic        clk;
    logic        rstN;
    logic [31:0] instAddr;
    logic [31:0] instData;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic [31:0] dataRdata;
    logic [3:0]  dataByteEn;
    logic        grfWe;
    logic [4:0]  grfAddr;
    logic [31:0] grfWdata;
    logic [31:0] wbPc;
    logic        loaded;
    int          wbIdx;
    int          cycles;
    int          cycleLimit;

    mipsCore uut (
        .clk(clk), .rstN(rstN),
        .instData(instData), .dataRdata(dataRdata),
        .instAddr(instAddr), .dataAddr(dataAddr),
        .dataWdata(dataWdata), .dataByteEn(dataByteEn),
        .grfWe(grfWe), .grfAddr(grfAddr), .grfWdata(grfWdata), .wbPc(wbPc)
    );

    tbMemModel mem (
        .clk(clk),
        .instAddr(instAddr), .instData(instData),
        .dataAddr(dataAddr), .dataWdata(dataWdata),
        .dataByteEn(dataByteEn), .dataRdata(dataRdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual)
            failRun($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic checkWriteback();
        string name;
        name = $sformatf("wb#%0d", wbIdx);
        checkValue({name, " pc"}, mem.expPc[wbIdx], wbPc);
        checkValue({name, " reg"}, {27'd0, mem.expReg[wbIdx]}, {27'd0, grfAddr});
        checkValue({name, " value"}, mem.expVal[wbIdx], grfWdata);
        wbIdx++;
    endtask

    task automatic checkMemory();
        for (int i = 0; i < mem.memCount; i++)
            checkValue($sformatf("mem@%h", mem.memAddr[i]), mem.memWord[i],
                       mem.peekWord(mem.memAddr[i]));
    endtask

    initial begin
        rstN       = 1'b0;
        wbIdx      = 0;
        cycles     = 0;
        cycleLimit = 40;
        mem.loadCases(loaded);
        if (!loaded) begin
            failRun("could not open or parse the cases file sim/mipsCoreCases.txt");
        end else begin
            // Room for stalls, branches and the pipeline fill
            cycleLimit = 4 * mem.progCount + 40;
            repeat (3) @(posedge clk);
            rstN <= 1'b1;
        end
    end

    // Writeback outputs are registered, so they sit still at the falling edge
    always @(negedge clk) begin
        if (rstN) begin
            cycles++;
            if (grfWe && grfAddr != 5'd0)
                checkWriteback();
            if (wbIdx == mem.wbCount) begin
                checkMemory();
                $display("Finished with no errors");
                $finish;
            end else if (cycles >= cycleLimit) begin
                failRun("trace did not finish before the cycle limit");
            end
        end
    end

endmodule

// ==== sim/mipsCoreCases.txt ====
# P addr word, D addr word, W pc reg value, M addr word
# Everything in hex except the W register number, which is decimal
P 3000 3C011234
P 3004 34215678
P 3008 2402FFFB
P 300C 00221821
P 3010 00612023
P 3014 0080282A
P 3018 00A23025
P 301C 24200007
P 3020 00013821
P 3024 24080100
P 3028 24090080
P 302C A1090000
P 3030 A1020001
P 3034 A1010002
P 3038 A1050003
P 303C AD070004
P 3040 8D0B0000
P 3044 016B6021
P 3048 810D0000
P 304C 810E0001
P 3050 810F0002
P 3054 24100003
P 3058 24110000
P 305C 2610FFFF
P 3060 1600FFFE
P 3064 26310001
P 3068 12300002
P 306C 3412AAAA
P 3070 12000002
P 3074 24130055
P 3078 24140066
P 307C AD110008
P 3080 0272A825
D 100 FFFFFFFF
D 104 DEADBEEF
D 108 00000000
D 10C CAFEF00D
# ALU chain and forwarding
W 3000 1 12340000
W 3004 1 12345678
W 3008 2 FFFFFFFB
W 300C 3 12345673
W 3010 4 FFFFFFFB
W 3014 5 00000001
W 3018 6 FFFFFFFB
W 3020 7 12345678
W 3024 8 00000100
W 3028 9 00000080
# Byte lanes, load-use and sign extension
W 3040 11 0178FB80
W 3044 12 02F1F700
W 3048 13 FFFFFF80
W 304C 14 FFFFFFFB
W 3050 15 00000078
# Loop with delay slots, then the two beq cases
W 3054 16 00000003
W 3058 17 00000000
W 305C 16 00000002
W 3064 17 00000001
W 305C 16 00000001
W 3064 17 00000002
W 305C 16 00000000
W 3064 17 00000003
W 306C 18 0000AAAA
W 3074 19 00000055
W 3080 21 0000AAFF
M 100 0178FB80
M 104 12345678
M 108 00000003
M 10C CAFEF00D

// ==== project.f ====
+incdir+include
rtl/mipsIsaPkg.sv
rtl/mipsPipePkg.sv
rtl/fetchUnit.sv
rtl/decodeUnit.sv
rtl/hazardUnit.sv
rtl/executeUnit.sv
rtl/memAccessUnit.sv
rtl/mipsCore.sv
sim/tbMemModel.sv
sim/tbMipsCore.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - include_dirs:
      - include
    files:
      - rtl/mipsIsaPkg.sv
      - rtl/mipsPipePkg.sv
      - rtl/fetchUnit.sv
      - rtl/decodeUnit.sv
      - rtl/hazardUnit.sv
      - rtl/executeUnit.sv
      - rtl/memAccessUnit.sv
      - rtl/mipsCore.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tbMemModel.sv
      - sim/tbMipsCore.sv
